//--- l2c_cfg_pkg.sv
package l2c_cfg_pkg;

  // line address and request tag
  localparam int ADDR_W = 37;
  localparam int TAG_W  = 4;   // 16 outstanding tags

  // reply bus data word
  localparam int DATA_W = 64;

  // bus agent identity
  localparam int ID_W  = 5;
  localparam int MY_ID = 3;

  // queue depths
  localparam int READ_DEPTH = 16;
  localparam int MISS_DEPTH = 16;  // one slot per tag, never overflows

  // read queue level that warns the core
  localparam int STALL_CNT = 12;

  // read command to miss report, in cycles
  localparam int LOOKUP_LAT = 4;

endpackage

//--- l2c_bus_pkg.sv
package l2c_bus_pkg;

  typedef struct packed {
    logic       io;
    logic [4:0] size;
    logic [4:0] bank0;  // first bank
    logic [1:0] low;
  } side_info_t;

  typedef struct packed {
    logic [l2c_cfg_pkg::ADDR_W-1:0] addr;
    logic [l2c_cfg_pkg::TAG_W-1:0]  tag;
    logic                           dupl;
    logic                           want_excl;
    side_info_t                     side;
  } read_req_t;

  typedef struct packed {
    logic [l2c_cfg_pkg::ADDR_W-1:0] addr;
    logic [l2c_cfg_pkg::TAG_W-1:0]  tag;
    logic [l2c_cfg_pkg::ID_W-1:0]   src_id;
    logic                           want_excl;
    logic                           dupl;
    side_info_t                     side;
  } bus_req_t;

  typedef enum logic {
    mem_reply,
    expunge
  } reply_kind_e;

  // same reply word, read as line data or as the address being expunged
  typedef union packed {
    logic [l2c_cfg_pkg::DATA_W-1:0] data;
    struct packed {
      logic [l2c_cfg_pkg::DATA_W-l2c_cfg_pkg::ADDR_W-1:0] pad;
      logic [l2c_cfg_pkg::ADDR_W-1:0]                     addr;
    } exp;
  } reply_payload_u;

  typedef struct packed {
    logic                          valid;
    reply_kind_e                   kind;
    logic [l2c_cfg_pkg::ID_W-1:0]  dst_id;
    logic [l2c_cfg_pkg::TAG_W-1:0] dst_tag;
    reply_payload_u                payload;
  } bus_reply_t;

  typedef enum logic [1:0] {
    cmd_read,
    cmd_fill,
    cmd_expunge
  } cmd_kind_e;

  typedef struct packed {
    logic                           valid;
    cmd_kind_e                      kind;
    logic [l2c_cfg_pkg::ADDR_W-1:0] addr;
    logic [l2c_cfg_pkg::TAG_W-1:0]  tag;
    logic                           dupl;
    logic                           want_excl;
    logic [l2c_cfg_pkg::DATA_W-1:0] data;
  } cache_cmd_t;

endpackage

//--- l2c_queue.sv
`timescale 1ns/1ps

module l2c_queue #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 16
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         push,
  input  logic [WIDTH-1:0]             push_data,
  input  logic                         pop,
  output logic [WIDTH-1:0]             pop_data,
  output logic                         empty,
  output logic [$clog2(DEPTH+1)-1:0]   count
);

  logic [WIDTH-1:0]         mem [DEPTH];
  logic [$clog2(DEPTH)-1:0] wr_ptr;
  logic [$clog2(DEPTH)-1:0] rd_ptr;
  logic                     push_ok;
  logic                     pop_ok;

  assign empty    = (count == '0);
  assign push_ok  = push && (count != DEPTH);  // full queue drops the push
  assign pop_ok   = pop && !empty;
  assign pop_data = mem[rd_ptr];

  always_ff @(posedge clk)
  begin
    if (push_ok)
      mem[wr_ptr] <= push_data;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push_ok)
        wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      if (pop_ok)
        rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      if (push_ok && !pop_ok)
        count <= count + 1'b1;
      else if (pop_ok && !push_ok)
        count <= count - 1'b1;
    end
  end

endmodule

//--- l2c_read_unit.sv
`timescale 1ns/1ps

module l2c_read_unit (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    read_en,
  input  l2c_bus_pkg::read_req_t  read_req,
  input  logic                    grant,
  output l2c_bus_pkg::read_req_t  head,
  output logic                    head_valid,
  output logic                    read_skip,
  output l2c_bus_pkg::side_info_t miss_side
);

  logic                                                q_empty;
  logic [$clog2(l2c_cfg_pkg::READ_DEPTH+1)-1:0]        q_count;
  l2c_bus_pkg::side_info_t side_dly [l2c_cfg_pkg::LOOKUP_LAT+1];

  l2c_queue #(
    .WIDTH ($bits(l2c_bus_pkg::read_req_t)),
    .DEPTH (l2c_cfg_pkg::READ_DEPTH)
  ) read_q_inst (
    .clk       (clk),
    .rst       (rst),
    .push      (read_en),
    .push_data (read_req),
    .pop       (grant),
    .pop_data  (head),
    .empty     (q_empty),
    .count     (q_count)
  );

  assign head_valid = !q_empty;

  always_ff @(posedge clk)
  begin
    if (rst)
      read_skip <= 1'b0;
    else
      read_skip <= (q_count >= l2c_cfg_pkg::STALL_CNT);
  end

  // stage 0 loads at the grant edge, last stage meets miss_en
  always_ff @(posedge clk)
  begin
    side_dly[0] <= head.side;
    for (int i = 1; i <= l2c_cfg_pkg::LOOKUP_LAT; i++)
      side_dly[i] <= side_dly[i-1];
  end

  assign miss_side = side_dly[l2c_cfg_pkg::LOOKUP_LAT];

endmodule

//--- l2c_miss_unit.sv
`timescale 1ns/1ps

module l2c_miss_unit (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           miss_en,
  input  logic [l2c_cfg_pkg::ADDR_W-1:0] miss_addr,
  input  logic [l2c_cfg_pkg::TAG_W-1:0]  miss_tag,
  input  logic                           miss_dupl,
  input  logic                           miss_want_excl,
  input  l2c_bus_pkg::side_info_t        miss_side,
  input  logic                           rbus_can,
  input  l2c_bus_pkg::bus_reply_t        rbus_reply,
  output l2c_bus_pkg::bus_req_t          rbus_req,
  output logic                           rbus_want,
  output l2c_bus_pkg::cache_cmd_t        ins_cmd
);

  l2c_bus_pkg::bus_req_t          miss_entry;
  logic                           miss_empty;
  l2c_bus_pkg::bus_reply_t        rpl_q;
  logic [l2c_cfg_pkg::ADDR_W-1:0] tbl_addr [l2c_cfg_pkg::MISS_DEPTH];
  logic                           tbl_dupl [l2c_cfg_pkg::MISS_DEPTH];

  always_comb
  begin
    miss_entry.addr      = miss_addr;
    miss_entry.tag       = miss_tag;
    miss_entry.src_id    = l2c_cfg_pkg::ID_W'(l2c_cfg_pkg::MY_ID);
    miss_entry.want_excl = miss_want_excl;
    miss_entry.dupl      = miss_dupl;
    miss_entry.side      = miss_side;
  end

  l2c_queue #(
    .WIDTH ($bits(l2c_bus_pkg::bus_req_t)),
    .DEPTH (l2c_cfg_pkg::MISS_DEPTH)
  ) miss_q_inst (
    .clk       (clk),
    .rst       (rst),
    .push      (miss_en),
    .push_data (miss_entry),
    .pop       (rbus_want && rbus_can),  // head leaves on can & want
    .pop_data  (rbus_req),
    .empty     (miss_empty),
    .count     ()
  );

  assign rbus_want = !miss_empty;

  // outstanding misses, by tag
  always_ff @(posedge clk)
  begin
    if (miss_en)
    begin
      tbl_addr[miss_tag] <= miss_addr;
      tbl_dupl[miss_tag] <= miss_dupl;
    end
  end

  always_ff @(posedge clk)
  begin
    rpl_q <= rbus_reply;
    if (rst)
      rpl_q.valid <= 1'b0;
  end

  always_comb
  begin
    ins_cmd     = '0;
    ins_cmd.tag = rpl_q.dst_tag;
    if (rpl_q.kind == l2c_bus_pkg::expunge)
    begin
      ins_cmd.valid = rpl_q.valid;  // expunges are for everyone
      ins_cmd.kind  = l2c_bus_pkg::cmd_expunge;
      ins_cmd.addr  = rpl_q.payload.exp.addr;
    end
    else
    begin
      ins_cmd.valid = rpl_q.valid && (rpl_q.dst_id == l2c_cfg_pkg::MY_ID);
      ins_cmd.kind  = l2c_bus_pkg::cmd_fill;
      ins_cmd.addr  = tbl_addr[rpl_q.dst_tag];
      ins_cmd.dupl  = tbl_dupl[rpl_q.dst_tag];
      ins_cmd.data  = rpl_q.payload.data;
    end
  end

endmodule

//--- l2c_cache_arb.sv
`timescale 1ns/1ps

module l2c_cache_arb (
  input  logic                    clk,
  input  logic                    rst,
  input  l2c_bus_pkg::cache_cmd_t ins_cmd,
  input  l2c_bus_pkg::read_req_t  head,
  input  logic                    head_valid,
  input  logic                    cache_ready,
  output logic                    grant,
  output l2c_bus_pkg::cache_cmd_t cache_cmd
);

  l2c_bus_pkg::cache_cmd_t next_cmd;

  // fills and expunges never wait, reads need cache_ready
  assign grant = !ins_cmd.valid && head_valid && cache_ready;

  always_comb
  begin
    if (ins_cmd.valid)
    begin
      next_cmd = ins_cmd;
    end
    else
    begin
      next_cmd.valid     = grant;
      next_cmd.kind      = l2c_bus_pkg::cmd_read;
      next_cmd.addr      = head.addr;
      next_cmd.tag       = head.tag;
      next_cmd.dupl      = head.dupl;
      next_cmd.want_excl = head.want_excl;
      next_cmd.data      = '0;
    end
  end

  always_ff @(posedge clk)
  begin
    cache_cmd <= next_cmd;
    if (rst)
      cache_cmd.valid <= 1'b0;
  end

endmodule

//--- l2c_cntrl.sv
`timescale 1ns/1ps

module l2c_cntrl (
  input  logic                           clk,
  input  logic                           rst,
  // core reads
  input  logic                           read_en,
  input  l2c_bus_pkg::read_req_t         read_req,
  output logic                           read_skip,
  // cache array
  output l2c_bus_pkg::cache_cmd_t        cache_cmd,
  input  logic                           cache_ready,
  input  logic                           miss_en,
  input  logic [l2c_cfg_pkg::ADDR_W-1:0] miss_addr,
  input  logic [l2c_cfg_pkg::TAG_W-1:0]  miss_tag,
  input  logic                           miss_dupl,
  input  logic                           miss_want_excl,
  // request and reply bus
  output l2c_bus_pkg::bus_req_t          rbus_req,
  output logic                           rbus_want,
  input  logic                           rbus_can,
  input  l2c_bus_pkg::bus_reply_t        rbus_reply
);

  l2c_bus_pkg::read_req_t  head;
  logic                    head_valid;
  logic                    grant;
  l2c_bus_pkg::side_info_t miss_side;
  l2c_bus_pkg::cache_cmd_t ins_cmd;

  l2c_read_unit read_unit_inst (
    .clk        (clk),
    .rst        (rst),
    .read_en    (read_en),
    .read_req   (read_req),
    .grant      (grant),
    .head       (head),
    .head_valid (head_valid),
    .read_skip  (read_skip),
    .miss_side  (miss_side)
  );

  l2c_miss_unit miss_unit_inst (
    .clk            (clk),
    .rst            (rst),
    .miss_en        (miss_en),
    .miss_addr      (miss_addr),
    .miss_tag       (miss_tag),
    .miss_dupl      (miss_dupl),
    .miss_want_excl (miss_want_excl),
    .miss_side      (miss_side),
    .rbus_can       (rbus_can),
    .rbus_reply     (rbus_reply),
    .rbus_req       (rbus_req),
    .rbus_want      (rbus_want),
    .ins_cmd        (ins_cmd)
  );

  l2c_cache_arb cache_arb_inst (
    .clk         (clk),
    .rst         (rst),
    .ins_cmd     (ins_cmd),
    .head        (head),
    .head_valid  (head_valid),
    .cache_ready (cache_ready),
    .grant       (grant),
    .cache_cmd   (cache_cmd)
  );

endmodule

//--- tb_l2c_cntrl.sv
`timescale 1ns/1ps

module tb_l2c_cntrl;

  localparam int LAT = l2c_cfg_pkg::LOOKUP_LAT;
  localparam int IDLE_LIMIT = 200;
  // cycle budget of each test from reset to expunge
  localparam int BUDGET = 20 + 260 + 240 + 260 + 420 + 420;

  typedef struct packed {
    logic                   miss;  // cache model reports a miss for it
    l2c_bus_pkg::read_req_t req;
  } exp_read_t;

  typedef struct {
    int                      cyc;
    l2c_bus_pkg::cache_cmd_t cmd;
  } exp_ins_t;

  logic                           clk = 1'b0;
  logic                           rst = 1'b1;
  logic                           read_en = 1'b0;
  l2c_bus_pkg::read_req_t         read_req = '0;
  logic                           read_skip;
  l2c_bus_pkg::cache_cmd_t        cache_cmd;
  logic                           cache_ready = 1'b0;
  logic                           miss_en = 1'b0;
  logic [l2c_cfg_pkg::ADDR_W-1:0] miss_addr = '0;
  logic [l2c_cfg_pkg::TAG_W-1:0]  miss_tag = '0;
  logic                           miss_dupl = 1'b0;
  logic                           miss_want_excl = 1'b0;
  l2c_bus_pkg::bus_req_t          rbus_req;
  logic                           rbus_want;
  logic                           rbus_can = 1'b0;
  l2c_bus_pkg::bus_reply_t        rbus_reply = '0;

  int                             cyc = 0;
  int                             errors = 0;
  int                             checks = 0;
  int                             tests = 0;
  int                             test_errors = 0;
  string                          test_name = "reset";
  exp_read_t                      read_q [$];
  exp_ins_t                       ins_q [$];
  l2c_bus_pkg::bus_req_t          bus_q [$];
  exp_read_t                      lat_r [LAT];
  logic [LAT-1:0]                 lat_v = '0;
  logic [l2c_cfg_pkg::ADDR_W-1:0] tag_addr [16];  // what the miss table should hold
  logic                           tag_dupl [16];

  l2c_cntrl l2c_cntrl_inst (.*);

  always #2 clk = ~clk;

  always @(posedge clk)
    cyc <= cyc + 1;

  task automatic report_error(input string msg);
    errors++;
    $display("ERROR in %s: %s", test_name, msg);
  endtask

  task automatic expect_equal(input string what, input logic [127:0] exp,
                              input logic [127:0] act);
    checks++;
    assert (act === exp)
    else
    begin
      errors++;
      $display("CHECK FAILED %s %s: expected %0h, actual %0h", test_name, what, exp, act);
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_errors = errors;
  endtask

  task automatic end_test();
    tests++;
    $display("test %s done, %0d errors", test_name, errors - test_errors);
  endtask

  task automatic send_read(input logic miss, input logic [l2c_cfg_pkg::TAG_W-1:0] tag);
    exp_read_t e;
    e.miss = miss;
    e.req.addr = l2c_cfg_pkg::ADDR_W'({$urandom, $urandom});
    e.req.tag = tag;
    e.req.dupl = 1'($urandom);
    e.req.want_excl = 1'($urandom);
    e.req.side = 13'($urandom);
    read_en = 1'b1;
    read_req = e.req;
    read_q.push_back(e);
  endtask

  task automatic send_reply(input l2c_bus_pkg::reply_kind_e kind,
                            input logic [l2c_cfg_pkg::ID_W-1:0] id,
                            input logic [l2c_cfg_pkg::TAG_W-1:0] tag);
    exp_ins_t e;
    rbus_reply.valid = 1'b1;
    rbus_reply.kind = kind;
    rbus_reply.dst_id = id;
    rbus_reply.dst_tag = tag;
    rbus_reply.payload = {$urandom, $urandom};
    e.cyc = cyc + 2;
    e.cmd = '0;
    e.cmd.tag = tag;
    if (kind == l2c_bus_pkg::expunge)
    begin
      e.cmd.kind = l2c_bus_pkg::cmd_expunge;
      e.cmd.addr = rbus_reply.payload.data[l2c_cfg_pkg::ADDR_W-1:0];  // low bits of the word
      ins_q.push_back(e);
    end
    else if (id == l2c_cfg_pkg::MY_ID)
    begin
      e.cmd.kind = l2c_bus_pkg::cmd_fill;
      e.cmd.addr = tag_addr[tag];
      e.cmd.dupl = tag_dupl[tag];
      e.cmd.data = rbus_reply.payload.data;
      ins_q.push_back(e);
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while ((read_q.size() != 0 || ins_q.size() != 0 || bus_q.size() != 0 || lat_v != '0
            || rbus_want) && n < IDLE_LIMIT)
    begin
      @(negedge clk);
      n++;
    end
    assert (n < IDLE_LIMIT)
    else report_error("timed out waiting for the controller to go idle");
  endtask

  // models the cache array and request bus mid-cycle
  always @(negedge clk)
  begin
    exp_read_t             er;
    exp_ins_t              ei;
    l2c_bus_pkg::bus_req_t eb;
    if (!rst)
    begin
      miss_en = lat_v[LAT-1];
      if (lat_v[LAT-1])
      begin
        er = lat_r[LAT-1];
        miss_addr = er.req.addr;
        miss_tag = er.req.tag;
        miss_dupl = er.req.dupl;
        miss_want_excl = er.req.want_excl;
        tag_addr[er.req.tag] = er.req.addr;
        tag_dupl[er.req.tag] = er.req.dupl;
        eb.addr = er.req.addr;
        eb.tag = er.req.tag;
        eb.src_id = l2c_cfg_pkg::ID_W'(l2c_cfg_pkg::MY_ID);
        eb.want_excl = er.req.want_excl;
        eb.dupl = er.req.dupl;
        eb.side = er.req.side;
        bus_q.push_back(eb);
      end
      for (int i = LAT - 1; i > 0; i--)
        lat_r[i] = lat_r[i-1];
      lat_v = {lat_v[LAT-2:0], 1'b0};
      if (cache_cmd.valid && cache_cmd.kind == l2c_bus_pkg::cmd_read)
      begin
        assert (read_q.size() != 0)
        else report_error("read command with no read pending");
        if (read_q.size() != 0)
        begin
          er = read_q.pop_front();
          expect_equal("read address", er.req.addr, cache_cmd.addr);
          expect_equal("read tag", er.req.tag, cache_cmd.tag);
          expect_equal("read dupl", er.req.dupl, cache_cmd.dupl);
          expect_equal("read want_excl", er.req.want_excl, cache_cmd.want_excl);
          lat_r[0] = er;
          lat_v[0] = er.miss;
        end
      end
      else if (cache_cmd.valid)
      begin
        assert (ins_q.size() != 0)
        else report_error("fill or expunge command with no reply behind it");
        if (ins_q.size() != 0)
        begin
          ei = ins_q.pop_front();
          expect_equal("insert cycle", ei.cyc, cyc);
          expect_equal("insert kind", ei.cmd.kind, cache_cmd.kind);
          expect_equal("insert address", ei.cmd.addr, cache_cmd.addr);
          expect_equal("insert tag", ei.cmd.tag, cache_cmd.tag);
          if (ei.cmd.kind == l2c_bus_pkg::cmd_fill)
          begin
            expect_equal("fill dupl", ei.cmd.dupl, cache_cmd.dupl);
            expect_equal("fill data", ei.cmd.data, cache_cmd.data);
          end
        end
      end
      if (ins_q.size() != 0)
      begin
        assert (ins_q[0].cyc >= cyc)
        else
        begin
          report_error("a reply to this controller produced no command");
          void'(ins_q.pop_front());
        end
      end
      rbus_can = 1'($urandom);
      if (rbus_want && rbus_can)  // transfers at the next rising edge
      begin
        assert (bus_q.size() != 0)
        else report_error("request bus entry with no miss behind it");
        if (bus_q.size() != 0)
          expect_equal("bus request", bus_q.pop_front(), rbus_req);
      end
    end
  end

  assert property (@(posedge clk) disable iff (rst)
    (rbus_want && !rbus_can) |=> $stable(rbus_req))
  else report_error("request bus entry changed while the bus could not take it");

  assert property (@(posedge clk) disable iff (rst)
    !cache_ready |=> !(cache_cmd.valid && cache_cmd.kind == l2c_bus_pkg::cmd_read))
  else report_error("read command issued while the cache was not ready");

  task automatic order_reads();
    begin_test("read_order");
    cache_ready = 1'b1;
    for (int i = 0; i < 24; i++)
    begin
      read_en = 1'b0;
      if ($urandom_range(3) != 0)
        send_read(1'b0, l2c_cfg_pkg::TAG_W'($urandom));
      @(negedge clk);
    end
    read_en = 1'b0;
    wait_idle();
    end_test();
  endtask

  task automatic stall_and_drain();
    int n;
    begin_test("stall");
    cache_ready = 1'b0;
    for (int i = 0; i < l2c_cfg_pkg::STALL_CNT; i++)
    begin
      assert (!read_skip)
      else report_error("read_skip high before the stall level was reached");
      send_read(1'b0, l2c_cfg_pkg::TAG_W'(i));
      @(negedge clk);
    end
    read_en = 1'b0;
    assert (!read_skip)  // still shows the level one below
    else report_error("read_skip high before the stall level was reached");
    n = 0;
    while (!read_skip && n < 8)
    begin
      @(negedge clk);
      n++;
    end
    assert (read_skip)
    else report_error("read_skip did not rise at the stall level");
    repeat (6) @(negedge clk);  // nothing may leave while not ready
    expect_equal("reads held", l2c_cfg_pkg::STALL_CNT, read_q.size());
    cache_ready = 1'b1;
    wait_idle();
    expect_equal("read_skip after drain", 1'b0, read_skip);
    end_test();
  endtask

  task automatic miss_to_bus();
    begin_test("miss_to_bus");
    for (int i = 0; i < 10; i++)
    begin
      send_read(1'b1, l2c_cfg_pkg::TAG_W'(i));  // tags kept unique
      @(negedge clk);
      read_en = 1'b0;
      repeat ($urandom_range(1)) @(negedge clk);
    end
    wait_idle();
    end_test();
  endtask

  task automatic fill_and_foreign();
    begin_test("fill");
    for (int t = 0; t < 3; t++)
    begin
      send_reply(l2c_bus_pkg::mem_reply, l2c_cfg_pkg::MY_ID, l2c_cfg_pkg::TAG_W'(t));
      @(negedge clk);
    end
    rbus_reply.valid = 1'b0;
    wait_idle();
    send_reply(l2c_bus_pkg::mem_reply, l2c_cfg_pkg::MY_ID + 1, 4'd3);  // another agent
    @(negedge clk);
    rbus_reply.valid = 1'b0;
    repeat (6) @(negedge clk);
    end_test();
  endtask

  task automatic expunge_with_reads();
    begin_test("expunge");
    send_reply(l2c_bus_pkg::expunge, l2c_cfg_pkg::ID_W'($urandom),
               l2c_cfg_pkg::TAG_W'($urandom));
    @(negedge clk);
    rbus_reply.valid = 1'b0;
    wait_idle();
    for (int i = 0; i < 8; i++)
    begin
      cache_ready = (i >= 3);  // let a few reads pile up first
      send_read(1'b0, l2c_cfg_pkg::TAG_W'($urandom));
      if (i == 4)
        send_reply(l2c_bus_pkg::expunge, l2c_cfg_pkg::ID_W'($urandom), 4'd7);
      else if (i == 6)
        send_reply(l2c_bus_pkg::mem_reply, l2c_cfg_pkg::MY_ID, 4'd5);
      @(negedge clk);
      rbus_reply.valid = 1'b0;
    end
    read_en = 1'b0;
    cache_ready = 1'b1;
    wait_idle();
    end_test();
  endtask

  initial
  begin
    void'($urandom(32'hf3cac1cd));
    repeat (16) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    begin_test("reset");
    expect_equal("cache_cmd.valid", 1'b0, cache_cmd.valid);
    expect_equal("rbus_want", 1'b0, rbus_want);
    expect_equal("read_skip", 1'b0, read_skip);
    end_test();
    order_reads();
    stall_and_drain();
    miss_to_bus();
    fill_and_foreign();
    expunge_with_reads();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

  initial
  begin
    #(BUDGET * 4 + 200);
    $display("watchdog expired before the tests finished");
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

//--- verilog.f
l2c_cfg_pkg.sv
l2c_bus_pkg.sv
l2c_queue.sv
l2c_read_unit.sv
l2c_miss_unit.sv
l2c_cache_arb.sv
l2c_cntrl.sv
tb_l2c_cntrl.sv

//--- Bender.yml
package:
  name: l2c_cntrl

sources:
  - l2c_cfg_pkg.sv
  - l2c_bus_pkg.sv
  - l2c_queue.sv
  - l2c_read_unit.sv
  - l2c_miss_unit.sv
  - l2c_cache_arb.sv
  - l2c_cntrl.sv
  - target: simulation
    files:
      - tb_l2c_cntrl.sv
